// ==== Makefile ====
TOP = tb_rsa_top

.PHONY: all run lint clean

all: run

# pass only when the simulation prints the pass line
run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only --timing -Wall --top-module rsa_top -f src.f

clean:
	rm -rf obj_dir

// ==== rtl/pe_row.sv ====
`timescale 1ns/1ns

`include "rsa_params.svh"

module pe_row
  import rsa_pkg::*;
(
  input  logic                         clk,
  input  logic                         sys_rst,
  input  logic                         i_acc_clr,
  input  logic [`RSA_X*`RSA_DW-1:0]    i_a_row,
  input  logic                         i_a_vld,
  input  logic [`RSA_X*`RSA_DW-1:0]    i_m_row,
  input  logic                         i_m_vld,
  output logic [`RSA_X*`RSA_ACC_W-1:0] o_acc
);

  localparam int X     = `RSA_X;
  localparam int DW    = `RSA_DW;
  localparam int ACC_W = `RSA_ACC_W;

  rsa_word_t               w_q   [X];  // latched weight vector
  rsa_word_t               a_w   [X];
  logic signed [ACC_W-1:0] prod  [X];
  logic        [ACC_W-1:0] acc_q [X];

  // signed lane products, sign extended to accumulator width
  always_comb begin
    for (int i = 0; i < X; i++) begin
      a_w[i]  = i_a_row[i*DW +: DW];
      prod[i] = $signed(a_w[i]) * $signed(w_q[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int i = 0; i < X; i++) begin
        w_q[i]   <= '0;
        acc_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < X; i++) begin
        if (i_m_vld) begin
          w_q[i] <= i_m_row[i*DW +: DW];
        end
        if (i_acc_clr) begin
          acc_q[i] <= '0;  // clear wins over accumulate
        end else if (i_a_vld) begin
          acc_q[i] <= acc_q[i] + prod[i];  // wraps mod 2**acc_w
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < X; i++) begin
      o_acc[i*ACC_W +: ACC_W] = acc_q[i];
    end
  end

endmodule

// ==== rtl/rsa_params.svh ====
`ifndef RSA_PARAMS_SVH
`define RSA_PARAMS_SVH

// ----------------------------------------------------------------------
// array geometry and widths
// ----------------------------------------------------------------------
`define RSA_X      4   // lanes per buffer row and per pe row, must be even
`define RSA_DW     16  // bits per lane word
`define RSA_ACC_W  40  // 2*dw plus 8 guard bits
`define RSA_TB_AW  6   // 64 rows in the tile buffer
`define RSA_LEN_W  4   // burst length field, rows minus one

`endif

// ==== rtl/rsa_pkg.sv ====
package rsa_pkg;

`include "rsa_params.svh"

  // ----------------------------------------------------------------------
  // lane mapping mode and operand target
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    DIR_IDLE = 2'b00,  // all lanes zero
    DIR_POS  = 2'b01,  // pass-through
    DIR_NEG  = 2'b10,  // lane reversal
    DIR_NEW  = 2'b11   // half-select by l_k_0
  } map_dir_t;

  typedef enum logic {
    TGT_A = 1'b0,  // activation path
    TGT_M = 1'b1   // weight path
  } map_tgt_t;

  // one lane word
  typedef logic [`RSA_DW-1:0] rsa_word_t;

endpackage

// ==== rtl/rsa_top.sv ====
`timescale 1ns/1ns

`include "rsa_params.svh"

module rsa_top
  import rsa_pkg::*;
(
  input  logic                         clk,
  input  logic                         sys_rst,
  // buffer write
  input  logic                         i_wr_en,
  input  logic [`RSA_TB_AW-1:0]        i_wr_addr,
  input  logic [`RSA_X*`RSA_DW-1:0]    i_wr_row,
  // read command
  input  logic                         i_rd_start,
  input  logic [`RSA_TB_AW-1:0]        i_rd_addr,
  input  logic [`RSA_LEN_W-1:0]        i_rd_len,
  input  map_tgt_t                     i_rd_tgt,
  input  map_dir_t                     i_rd_dir,
  input  logic                         i_l_k_0,
  input  logic                         i_acc_clr,
  output logic                         o_busy,
  // mapped operands and results
  output logic [`RSA_X*`RSA_DW-1:0]    o_a_row,
  output logic                         o_a_vld,
  output logic [`RSA_X*`RSA_DW-1:0]    o_m_row,
  output logic                         o_m_vld,
  output logic [`RSA_X*`RSA_ACC_W-1:0] o_acc
);

  logic                      rd_en;
  logic [`RSA_TB_AW-1:0]     rd_addr;
  logic [`RSA_X*`RSA_DW-1:0] rd_row;
  logic                      row_vld;   // aligned with rd_row
  map_tgt_t                  row_tgt;
  map_dir_t                  row_dir;
  logic                      row_l_k_0;

  tb_read_ctrl u_read_ctrl (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_rd_start (i_rd_start),
    .i_rd_addr  (i_rd_addr),
    .i_rd_len   (i_rd_len),
    .i_rd_tgt   (i_rd_tgt),
    .i_rd_dir   (i_rd_dir),
    .i_l_k_0    (i_l_k_0),
    .o_busy     (o_busy),
    .o_rd_en    (rd_en),
    .o_rd_addr  (rd_addr),
    .o_vld      (row_vld),
    .o_tgt      (row_tgt),
    .o_dir      (row_dir),
    .o_l_k_0    (row_l_k_0)
  );

  tile_buffer u_tile_buffer (
    .clk       (clk),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_row  (i_wr_row),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_row  (rd_row)
  );

  tb_douta_map u_douta_map (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_vld   (row_vld),
    .i_tgt   (row_tgt),
    .i_dir   (row_dir),
    .i_l_k_0 (row_l_k_0),
    .i_douta (rd_row),
    .o_a_row (o_a_row),
    .o_a_vld (o_a_vld),
    .o_m_row (o_m_row),
    .o_m_vld (o_m_vld)
  );

  pe_row u_pe_row (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_acc_clr (i_acc_clr),
    .i_a_row   (o_a_row),
    .i_a_vld   (o_a_vld),
    .i_m_row   (o_m_row),
    .i_m_vld   (o_m_vld),
    .o_acc     (o_acc)
  );

endmodule

// ==== rtl/tb_douta_map.sv ====
`timescale 1ns/1ns

`include "rsa_params.svh"

module tb_douta_map
  import rsa_pkg::*;
(
  input  logic                      clk,
  input  logic                      sys_rst,
  input  logic                      i_vld,
  input  map_tgt_t                  i_tgt,
  input  map_dir_t                  i_dir,
  input  logic                      i_l_k_0,
  input  logic [`RSA_X*`RSA_DW-1:0] i_douta,
  output logic [`RSA_X*`RSA_DW-1:0] o_a_row,
  output logic                      o_a_vld,
  output logic [`RSA_X*`RSA_DW-1:0] o_m_row,
  output logic                      o_m_vld
);

  localparam int X    = `RSA_X;
  localparam int DW   = `RSA_DW;
  localparam int HALF = X / 2;

  logic [X*DW-1:0] map_row;
  logic            sel_a;
  logic            sel_m;

  assign sel_a = i_vld && (i_tgt == TGT_A);
  assign sel_m = i_vld && (i_tgt == TGT_M);

  // ----------------------------------------------------------------------
  // lane mapping, shared by both targets
  // ----------------------------------------------------------------------
  always_comb begin
    map_row = '0;
    case (i_dir)
      DIR_POS: begin
        map_row = i_douta;
      end
      DIR_NEG: begin
        for (int i = 0; i < X; i++) begin
          map_row[i*DW +: DW] = i_douta[(X-1-i)*DW +: DW];
        end
      end
      DIR_NEW: begin
        // chosen half goes to the low lanes, upper lanes stay zero
        for (int i = 0; i < HALF; i++) begin
          if (i_l_k_0) begin
            map_row[i*DW +: DW] = i_douta[i*DW +: DW];
          end else begin
            map_row[i*DW +: DW] = i_douta[(HALF+i)*DW +: DW];
          end
        end
      end
      default: begin
        map_row = '0;  // idle
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // steered output registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_a_row <= '0;
      o_a_vld <= 1'b0;
      o_m_row <= '0;
      o_m_vld <= 1'b0;
    end else begin
      o_a_row <= sel_a ? map_row : '0;  // unselected path carries zero
      o_a_vld <= sel_a;
      o_m_row <= sel_m ? map_row : '0;
      o_m_vld <= sel_m;
    end
  end

endmodule

// ==== rtl/tb_read_ctrl.sv ====
`timescale 1ns/1ns

`include "rsa_params.svh"

module tb_read_ctrl
  import rsa_pkg::*;
(
  input  logic                  clk,
  input  logic                  sys_rst,
  // read command
  input  logic                  i_rd_start,
  input  logic [`RSA_TB_AW-1:0] i_rd_addr,
  input  logic [`RSA_LEN_W-1:0] i_rd_len,
  input  map_tgt_t              i_rd_tgt,
  input  map_dir_t              i_rd_dir,
  input  logic                  i_l_k_0,
  output logic                  o_busy,
  // buffer read side
  output logic                  o_rd_en,
  output logic [`RSA_TB_AW-1:0] o_rd_addr,
  // aligned with buffer read data
  output logic                  o_vld,
  output map_tgt_t              o_tgt,
  output map_dir_t              o_dir,
  output logic                  o_l_k_0
);

  logic [`RSA_TB_AW-1:0] nxt_addr;   // next row to issue
  logic [`RSA_LEN_W-1:0] remain;     // rows left after the current one
  map_tgt_t              cmd_tgt;
  map_dir_t              cmd_dir;
  logic                  cmd_l_k_0;
  logic                  accept;

  assign accept = i_rd_start && !o_busy;  // pulse while busy is dropped

  // ----------------------------------------------------------------------
  // burst counter and address issue
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_busy    <= 1'b0;
      o_rd_en   <= 1'b0;
      o_rd_addr <= '0;
      nxt_addr  <= '0;
      remain    <= '0;
      cmd_tgt   <= TGT_A;
      cmd_dir   <= DIR_IDLE;
      cmd_l_k_0 <= 1'b0;
    end else if (accept) begin
      o_busy    <= 1'b1;
      o_rd_en   <= 1'b0;
      nxt_addr  <= i_rd_addr;
      remain    <= i_rd_len;
      cmd_tgt   <= i_rd_tgt;
      cmd_dir   <= i_rd_dir;
      cmd_l_k_0 <= i_l_k_0;
    end else if (o_busy) begin
      o_rd_en   <= 1'b1;
      o_rd_addr <= nxt_addr;
      nxt_addr  <= nxt_addr + 1'b1;  // wraps at buffer end
      remain    <= remain - 1'b1;
      if (remain == '0) begin
        o_busy <= 1'b0;  // last address issued
      end
    end else begin
      o_rd_en <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // one stage delay to meet the registered buffer read
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_vld   <= 1'b0;
      o_tgt   <= TGT_A;
      o_dir   <= DIR_IDLE;
      o_l_k_0 <= 1'b0;
    end else begin
      o_vld   <= o_rd_en;
      o_tgt   <= cmd_tgt;    // next command lands after the last row samples this
      o_dir   <= cmd_dir;
      o_l_k_0 <= cmd_l_k_0;
    end
  end

endmodule

// ==== rtl/tile_buffer.sv ====
`timescale 1ns/1ns

`include "rsa_params.svh"

module tile_buffer (
  input  logic                         clk,
  input  logic                         i_wr_en,
  input  logic [`RSA_TB_AW-1:0]        i_wr_addr,
  input  logic [`RSA_X*`RSA_DW-1:0]    i_wr_row,
  input  logic                         i_rd_en,
  input  logic [`RSA_TB_AW-1:0]        i_rd_addr,
  output logic [`RSA_X*`RSA_DW-1:0]    o_rd_row
);

  localparam int DEPTH = 2 ** `RSA_TB_AW;
  localparam int ROW_W = `RSA_X * `RSA_DW;

  logic [ROW_W-1:0] mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_row;
    end
  end

  // registered read, holds when not enabled
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_row <= mem[i_rd_addr];  // one cycle latency
    end
  end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/rsa_pkg.sv
rtl/tile_buffer.sv
rtl/tb_read_ctrl.sv
rtl/tb_douta_map.sv
rtl/pe_row.sv
rtl/rsa_top.sv
test/tb_rsa_top.sv

// ==== test/tb_rsa_top.sv ====
`timescale 1ns/1ns

`include "rsa_params.svh"

module tb_rsa_top
  import rsa_pkg::*;
();

  localparam int X     = `RSA_X;
  localparam int DW    = `RSA_DW;
  localparam int ACC_W = `RSA_ACC_W;
  localparam int ROW_W = X * DW;
  localparam int DEPTH = 2 ** `RSA_TB_AW;

  typedef struct packed {
    logic [`RSA_TB_AW-1:0] addr;
    logic [`RSA_LEN_W-1:0] len;
    map_tgt_t              tgt;
    map_dir_t              dir;
    logic                  lk;    // l_k_0
    logic                  clr;   // drain and clear accumulators first
    logic                  poke;  // extra start pulse while busy
    logic                  b2b;   // next burst follows at once, no acc check
  } stim_t;

  logic                  clk;
  logic                  sys_rst;
  logic                  i_wr_en;
  logic [`RSA_TB_AW-1:0] i_wr_addr;
  logic [ROW_W-1:0]      i_wr_row;
  logic                  i_rd_start;
  logic [`RSA_TB_AW-1:0] i_rd_addr;
  logic [`RSA_LEN_W-1:0] i_rd_len;
  map_tgt_t              i_rd_tgt;
  map_dir_t              i_rd_dir;
  logic                  i_l_k_0;
  logic                  i_acc_clr;
  logic                  o_busy;
  logic [ROW_W-1:0]      o_a_row;
  logic                  o_a_vld;
  logic [ROW_W-1:0]      o_m_row;
  logic                  o_m_vld;
  logic [X*ACC_W-1:0]    o_acc;

  stim_t            tbl [$];
  logic [ROW_W-1:0] mem_m [DEPTH];  // mirror of buffer contents
  rsa_word_t        w_m [X];
  logic [ACC_W-1:0] acc_m [X];
  logic [ROW_W-1:0] exp_rows [$];
  map_tgt_t         exp_tgts [$];
  logic [ROW_W-1:0] e_row;
  map_tgt_t         e_tgt;
  logic [31:0]      lfsr;
  int               val_err;
  int               seq_err;
  int               rows_seen;
  int               rows_exp;

  rsa_top dut0 (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
  endfunction

  function automatic logic [ROW_W-1:0] rand_row();
    logic [ROW_W-1:0] r;
    r = '0;
    for (int b = 0; b < ROW_W; b++) begin
      r = {r[ROW_W-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);  // one step per bit
    end
    return r;
  endfunction

  function automatic logic [ROW_W-1:0] map_model(input logic [ROW_W-1:0] row,
                                                  input map_dir_t dir, input logic lk);
    logic [ROW_W-1:0] out;
    int               base;
    out  = '0;
    base = lk ? 0 : X / 2;  // l_k_0 high takes the low half
    for (int i = 0; i < X; i++) begin
      case (dir)
        DIR_POS: out[i*DW +: DW] = row[i*DW +: DW];
        DIR_NEG: out[i*DW +: DW] = row[(X-1-i)*DW +: DW];
        DIR_NEW: if (i < X / 2) out[i*DW +: DW] = row[(base+i)*DW +: DW];
        default: out[i*DW +: DW] = '0;
      endcase
    end
    return out;
  endfunction

  function automatic logic [X*ACC_W-1:0] acc_flat();
    logic [X*ACC_W-1:0] f;
    for (int i = 0; i < X; i++) begin
      f[i*ACC_W +: ACC_W] = acc_m[i];
    end
    return f;
  endfunction

  task automatic check_eq(input string name, input logic [X*ACC_W-1:0] exp,
                          input logic [X*ACC_W-1:0] got);
    assert (got === exp) else begin
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      val_err++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (o_busy && n < 100) begin
      @(negedge clk);
      n++;
    end
    assert (!o_busy) else begin
      $display("timeout while waiting for o_busy to fall");
      seq_err++;
    end
  endtask

  // expected rows, weights and accumulators for one burst
  task automatic queue_burst(input stim_t s);
    logic [ROW_W-1:0]        m;
    logic [`RSA_TB_AW-1:0]   a;
    logic signed [ACC_W-1:0] p;
    a = s.addr;
    for (int k = 0; k <= int'(s.len); k++) begin
      m = map_model(mem_m[a], s.dir, s.lk);
      exp_rows.push_back(m);
      exp_tgts.push_back(s.tgt);
      rows_exp++;
      for (int i = 0; i < X; i++) begin
        if (s.tgt == TGT_M) begin
          w_m[i] = m[i*DW +: DW];
        end else begin
          p = $signed(m[i*DW +: DW]) * $signed(w_m[i]);
          acc_m[i] = acc_m[i] + p;  // wraps like the hardware
        end
      end
      a = a + 1'b1;
    end
  endtask

  task automatic pulse_start(input logic [`RSA_TB_AW-1:0] addr,
                             input logic [`RSA_LEN_W-1:0] len, input map_tgt_t tgt,
                             input map_dir_t dir, input logic lk);
    i_rd_start = 1'b1;
    i_rd_addr  = addr;
    i_rd_len   = len;
    i_rd_tgt   = tgt;
    i_rd_dir   = dir;
    i_l_k_0    = lk;
    @(negedge clk);
    i_rd_start = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // mapper output monitor
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    if (!sys_rst && (o_a_vld || o_m_vld)) begin
      rows_seen++;
      assert (exp_rows.size() > 0) else begin
        $display("valid row seen with no row left in the expected sequence");
        seq_err++;
      end
      if (exp_rows.size() > 0) begin
        e_row = exp_rows.pop_front();
        e_tgt = exp_tgts.pop_front();
        check_eq("o_a_vld", e_tgt == TGT_A, o_a_vld);
        check_eq("o_m_vld", e_tgt == TGT_M, o_m_vld);
        check_eq("o_a_row", (e_tgt == TGT_A) ? e_row : '0, o_a_row);
        check_eq("o_m_row", (e_tgt == TGT_M) ? e_row : '0, o_m_row);
      end
    end
  end

  initial begin
    clk        = 1'b0;
    sys_rst    = 1'b1;
    i_wr_en    = 1'b0;
    i_wr_addr  = '0;
    i_wr_row   = '0;
    i_rd_start = 1'b0;
    i_rd_addr  = '0;
    i_rd_len   = '0;
    i_rd_tgt   = TGT_A;
    i_rd_dir   = DIR_IDLE;
    i_l_k_0    = 1'b0;
    i_acc_clr  = 1'b0;
    lfsr       = 32'hc78d2545;
    val_err    = 0;
    seq_err    = 0;
    rows_seen  = 0;
    rows_exp   = 0;
    for (int i = 0; i < X; i++) begin
      w_m[i]   = '0;
      acc_m[i] = '0;
    end
    // addr, len, tgt, dir, l_k_0, clr, poke, b2b
    tbl.push_back('{6'd2,  4'd3,  TGT_A, DIR_POS,  1'b0, 1'b0, 1'b0, 1'b0});
    tbl.push_back('{6'd10, 4'd2,  TGT_M, DIR_NEG,  1'b0, 1'b0, 1'b0, 1'b0});
    tbl.push_back('{6'd20, 4'd1,  TGT_A, DIR_NEG,  1'b0, 1'b0, 1'b0, 1'b0});
    tbl.push_back('{6'd30, 4'd0,  TGT_M, DIR_POS,  1'b0, 1'b0, 1'b0, 1'b0});
    tbl.push_back('{6'd40, 4'd3,  TGT_A, DIR_NEW,  1'b1, 1'b0, 1'b0, 1'b0});
    tbl.push_back('{6'd44, 4'd3,  TGT_A, DIR_NEW,  1'b0, 1'b0, 1'b0, 1'b0});
    tbl.push_back('{6'd50, 4'd2,  TGT_M, DIR_NEW,  1'b1, 1'b0, 1'b0, 1'b0});
    tbl.push_back('{6'd60, 4'd5,  TGT_A, DIR_IDLE, 1'b0, 1'b0, 1'b0, 1'b0});
    tbl.push_back('{6'd8,  4'd0,  TGT_M, DIR_POS,  1'b0, 1'b1, 1'b0, 1'b0});
    tbl.push_back('{6'd12, 4'd7,  TGT_A, DIR_POS,  1'b0, 1'b0, 1'b1, 1'b0});
    tbl.push_back('{6'd33, 4'd4,  TGT_A, DIR_NEG,  1'b0, 1'b1, 1'b0, 1'b0});
    tbl.push_back('{6'd0,  4'd2,  TGT_M, DIR_NEG,  1'b0, 1'b0, 1'b0, 1'b1});
    tbl.push_back('{6'd5,  4'd3,  TGT_A, DIR_POS,  1'b0, 1'b0, 1'b0, 1'b1});
    tbl.push_back('{6'd17, 4'd15, TGT_A, DIR_NEW,  1'b0, 1'b0, 1'b0, 1'b0});

    repeat (10) @(negedge clk);
    sys_rst = 1'b0;
    check_eq("o_busy", 1'b0, o_busy);
    check_eq("o_a_vld", 1'b0, o_a_vld);
    check_eq("o_m_vld", 1'b0, o_m_vld);
    check_eq("o_acc", '0, o_acc);

    for (int r = 0; r < DEPTH; r++) begin
      mem_m[r]  = rand_row();
      i_wr_en   = 1'b1;
      i_wr_addr = r[`RSA_TB_AW-1:0];
      i_wr_row  = mem_m[r];
      @(negedge clk);
    end
    i_wr_en = 1'b0;

    // ----------------------------------------------------------------------
    // apply the stimulus table
    // ----------------------------------------------------------------------
    foreach (tbl[n]) begin
      if (tbl[n].clr) begin
        wait_idle();
        repeat (5) @(negedge clk);  // let the pipeline drain
        i_acc_clr = 1'b1;
        @(negedge clk);
        i_acc_clr = 1'b0;
        for (int i = 0; i < X; i++) begin
          acc_m[i] = '0;
        end
      end
      wait_idle();
      queue_burst(tbl[n]);
      pulse_start(tbl[n].addr, tbl[n].len, tbl[n].tgt, tbl[n].dir, tbl[n].lk);
      if (tbl[n].poke) begin
        pulse_start(6'd63, 4'd15, TGT_M, DIR_POS, 1'b0);  // must be dropped
      end
      if (!tbl[n].b2b) begin
        wait_idle();
        repeat (5) @(negedge clk);
        check_eq("o_acc", acc_flat(), o_acc);
        assert (exp_rows.size() == 0) else begin
          $display("burst at entry %0d left %0d rows undelivered", n, exp_rows.size());
          seq_err++;
        end
      end
    end

    check_eq("rows_seen", rows_exp, rows_seen);
    $display("errors: %0d value mismatches, %0d timeouts or sequence faults",
             val_err, seq_err);
    if (val_err == 0 && seq_err == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
